// File: cpu_pkg.sv
// Shared definitions for the reduced 6502-style core
// Bus widths, zero-page byte, opcode encodings
// Sequencer states and execute operations
`default_nettype none

package cpu_pkg;

    localparam int DATA_W = 8;                              // Data bus and A width
    localparam int ADDR_W = 16;                             // Address bus width

    localparam logic [DATA_W-1:0] ZEROPAGE = 8'h00;         // High byte of zp accesses

    // Loads and stores
    localparam logic [DATA_W-1:0] LDA_IMM  = 8'hA9;
    localparam logic [DATA_W-1:0] LDA_ZP   = 8'hA5;
    localparam logic [DATA_W-1:0] STA_ZP   = 8'h85;

    // ALU group, immediate and zero page
    localparam logic [DATA_W-1:0] ORA_IMM  = 8'h09;
    localparam logic [DATA_W-1:0] ORA_ZP   = 8'h05;
    localparam logic [DATA_W-1:0] AND_IMM  = 8'h29;
    localparam logic [DATA_W-1:0] AND_ZP   = 8'h25;
    localparam logic [DATA_W-1:0] EOR_IMM  = 8'h49;
    localparam logic [DATA_W-1:0] EOR_ZP   = 8'h45;
    localparam logic [DATA_W-1:0] ADC_IMM  = 8'h69;
    localparam logic [DATA_W-1:0] ADC_ZP   = 8'h65;
    localparam logic [DATA_W-1:0] SBC_IMM  = 8'hE9;
    localparam logic [DATA_W-1:0] SBC_ZP   = 8'hE5;
    localparam logic [DATA_W-1:0] CMP_IMM  = 8'hC9;
    localparam logic [DATA_W-1:0] CMP_ZP   = 8'hC5;

    // Carry flag and jump
    localparam logic [DATA_W-1:0] CLC_IMP  = 8'h18;         // Implied mode
    localparam logic [DATA_W-1:0] SEC_IMP  = 8'h38;
    localparam logic [DATA_W-1:0] JMP_ABS  = 8'h4C;

    // Branches, condition in bits 7:5
    localparam logic [DATA_W-1:0] BPL      = 8'h10;
    localparam logic [DATA_W-1:0] BMI      = 8'h30;
    localparam logic [DATA_W-1:0] BVC      = 8'h50;
    localparam logic [DATA_W-1:0] BVS      = 8'h70;
    localparam logic [DATA_W-1:0] BCC      = 8'h90;
    localparam logic [DATA_W-1:0] BCS      = 8'hB0;
    localparam logic [DATA_W-1:0] BNE      = 8'hD0;
    localparam logic [DATA_W-1:0] BEQ      = 8'hF0;

    typedef enum logic [3:0] {
        DECODE,     // Opcode in, first operand byte on the bus
        FETCH,      // ALU op done, next opcode on the bus
        REG,        // Implied op, next opcode on the bus
        ZP0,        // Zero-page read or STA write
        JMP0,       // Target low byte in
        JMP1,       // Target high byte in, fetch at target
        BRA0,       // Offset in, condition checked
        BRA1,       // Fetch at target, same page
        BRA2        // Fetch at target after page fix
    } state_t;

    typedef enum logic [3:0] {
        NONE, LDA, ORA, AND, EOR, ADC, SBC, CMP, CLC, SEC
    } alu_op_t;

endpackage

`default_nettype wire

// File: cpu_decode.sv
// Instruction decoder
// Opcode to state path, registered ALU op, store flag and branch condition
`timescale 1ns/100ps
`default_nettype none

module cpu_decode (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic [cpu_pkg::DATA_W-1:0] ir,          // Opcode byte from bus
    input  wire logic                       decode_en,   // DECODE with rdy high
    output cpu_pkg::state_t                 next_state,  // Path after DECODE
    output cpu_pkg::alu_op_t                alu_op,
    output logic                            store,       // STA in progress
    output logic [2:0]                      cond_code    // Branch condition bits
);

    cpu_pkg::alu_op_t op_dec;                               // Operation for current ir

    // State path by addressing mode
    always_comb begin
        case (ir)
            cpu_pkg::LDA_IMM, cpu_pkg::ORA_IMM, cpu_pkg::AND_IMM,
            cpu_pkg::EOR_IMM, cpu_pkg::ADC_IMM, cpu_pkg::SBC_IMM,
            cpu_pkg::CMP_IMM:
                next_state = cpu_pkg::FETCH;                // Operand follows opcode
            cpu_pkg::LDA_ZP, cpu_pkg::ORA_ZP, cpu_pkg::AND_ZP,
            cpu_pkg::EOR_ZP, cpu_pkg::ADC_ZP, cpu_pkg::SBC_ZP,
            cpu_pkg::CMP_ZP, cpu_pkg::STA_ZP:
                next_state = cpu_pkg::ZP0;
            cpu_pkg::JMP_ABS:
                next_state = cpu_pkg::JMP0;
            cpu_pkg::BPL, cpu_pkg::BMI, cpu_pkg::BVC, cpu_pkg::BVS,
            cpu_pkg::BCC, cpu_pkg::BCS, cpu_pkg::BNE, cpu_pkg::BEQ:
                next_state = cpu_pkg::BRA0;
            default:
                next_state = cpu_pkg::REG;                  // CLC, SEC, unknown
        endcase
    end

    // Operation for the execute unit
    always_comb begin
        case (ir)
            cpu_pkg::LDA_IMM, cpu_pkg::LDA_ZP: op_dec = cpu_pkg::LDA;
            cpu_pkg::ORA_IMM, cpu_pkg::ORA_ZP: op_dec = cpu_pkg::ORA;
            cpu_pkg::AND_IMM, cpu_pkg::AND_ZP: op_dec = cpu_pkg::AND;
            cpu_pkg::EOR_IMM, cpu_pkg::EOR_ZP: op_dec = cpu_pkg::EOR;
            cpu_pkg::ADC_IMM, cpu_pkg::ADC_ZP: op_dec = cpu_pkg::ADC;
            cpu_pkg::SBC_IMM, cpu_pkg::SBC_ZP: op_dec = cpu_pkg::SBC;
            cpu_pkg::CMP_IMM, cpu_pkg::CMP_ZP: op_dec = cpu_pkg::CMP;
            cpu_pkg::CLC_IMP:                  op_dec = cpu_pkg::CLC;
            cpu_pkg::SEC_IMP:                  op_dec = cpu_pkg::SEC;
            default:                           op_dec = cpu_pkg::NONE;  // STA, JMP, branches
        endcase
    end

    // Controls held for the rest of the instruction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            alu_op    <= cpu_pkg::NONE;
            store     <= 1'b0;
            cond_code <= 3'd0;
        end else if (decode_en) begin
            alu_op    <= op_dec;
            store     <= (ir == cpu_pkg::STA_ZP);           // Drives we_n in ZP0
            cond_code <= ir[7:5];                           // Flag select and sense
        end
    end

endmodule

`default_nettype wire

// File: cpu_sequencer.sv
// Sequencer FSM with program counter and address generation
// JMP low-byte latch, branch target adder with page check
// Read-data hold register for stalls, write enable
`timescale 1ns/100ps
`default_nettype none

module cpu_sequencer #(
    parameter logic [cpu_pkg::ADDR_W-1:0] RESET_PC = '0     // First opcode address
) (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       rdy,            // Low stalls the core
    input  wire logic [cpu_pkg::DATA_W-1:0] data_in,
    input  wire cpu_pkg::state_t            next_state,     // Decoded path
    input  wire logic                       store,
    input  wire logic                       cond_true,      // Branch taken
    output logic [cpu_pkg::DATA_W-1:0]      ir,
    output logic                            decode_en,
    output logic [cpu_pkg::DATA_W-1:0]      operand,
    output logic                            alu_en,
    output logic [cpu_pkg::ADDR_W-1:0]      addr,
    output logic                            we_n
);

    localparam int DW = cpu_pkg::DATA_W;
    localparam int AW = cpu_pkg::ADDR_W;

    cpu_pkg::state_t state;
    cpu_pkg::state_t state_nx;
    logic [AW-1:0]   pc;                                    // Address of byte on the bus
    logic [AW-1:0]   pc_next;
    logic [AW-1:0]   bra_target;                            // PC plus signed offset
    logic [DW-1:0]   bra_hi;                                // Target page for BRA1/BRA2
    logic [DW-1:0]   jmp_lo;                                // JMP target low byte
    logic [DW-1:0]   hold;                                  // Read byte seen at stall start
    logic            stall_q;                               // Previous cycle had rdy low
    logic            boot;                                  // First cycle out of reset
    logic [DW-1:0]   rd_byte;

    // Read path, live byte or the one captured when the stall began
    assign rd_byte = stall_q ? hold : data_in;
    assign ir      = rd_byte;
    assign operand = rd_byte;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            stall_q <= 1'b0;
        else
            stall_q <= ~rdy;
    end

    always_ff @(posedge clk) begin
        if (!stall_q)
            hold <= data_in;                                // Frozen while stall continues
    end

    assign decode_en = (state == cpu_pkg::DECODE) && rdy && !boot;
    assign alu_en    = ((state == cpu_pkg::FETCH) || (state == cpu_pkg::REG)) && rdy;

    // Offset is relative to the opcode after the branch
    assign bra_target = pc + {{(AW-DW){rd_byte[DW-1]}}, rd_byte};

    // Bus address
    always_comb begin
        case (state)
            cpu_pkg::ZP0:  addr = {cpu_pkg::ZEROPAGE, rd_byte};
            cpu_pkg::JMP1: addr = {rd_byte, jmp_lo};        // Opcode fetch at target
            default:       addr = pc;
        endcase
    end

    assign we_n = !((state == cpu_pkg::ZP0) && store);      // STA write cycle only

    // Next state and next PC
    always_comb begin
        state_nx = cpu_pkg::DECODE;
        pc_next  = addr + 16'd1;                            // Step past the byte on the bus
        case (state)
            cpu_pkg::DECODE: begin
                if (boot) begin
                    state_nx = cpu_pkg::DECODE;             // RESET_PC fetched this cycle
                end else begin
                    state_nx = next_state;
                    if (next_state == cpu_pkg::REG)
                        pc_next = pc;                       // Next opcode read in REG
                end
            end
            cpu_pkg::ZP0: begin
                state_nx = cpu_pkg::FETCH;
                pc_next  = pc;                              // Bus busy with zp access
            end
            cpu_pkg::JMP0: begin
                state_nx = cpu_pkg::JMP1;
                pc_next  = pc;
            end
            cpu_pkg::BRA0: begin
                if (cond_true) begin
                    state_nx = cpu_pkg::BRA1;
                    pc_next  = {pc[AW-1:DW], bra_target[DW-1:0]};  // Low byte first
                end
            end
            cpu_pkg::BRA1: begin
                if (bra_hi != pc[AW-1:DW]) begin
                    state_nx = cpu_pkg::BRA2;               // Page crossed, fix high byte
                    pc_next  = {bra_hi, pc[DW-1:0]};
                end
            end
            default: begin
                state_nx = cpu_pkg::DECODE;                 // FETCH, REG, JMP1, BRA2
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= cpu_pkg::DECODE;
            pc    <= RESET_PC;
            boot  <= 1'b1;
        end else if (rdy) begin
            state <= state_nx;
            pc    <= pc_next;
            boot  <= 1'b0;
        end
    end

    // Payload latches for JMP and taken branches
    always_ff @(posedge clk) begin
        if (rdy && (state == cpu_pkg::JMP0))
            jmp_lo <= rd_byte;
        if (rdy && (state == cpu_pkg::BRA0))
            bra_hi <= bra_target[AW-1:DW];                  // Compared with PC in BRA1
    end

endmodule

`default_nettype wire

// File: cpu_execute.sv
// Execute unit
// Accumulator, C Z N V flags, 8-bit ALU, branch condition select
`timescale 1ns/100ps
`default_nettype none

module cpu_execute (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       alu_en,     // FETCH or REG with rdy high
    input  wire cpu_pkg::alu_op_t           alu_op,
    input  wire logic [cpu_pkg::DATA_W-1:0] operand,
    input  wire logic [2:0]                 cond_code,
    output logic [cpu_pkg::DATA_W-1:0]      acc,        // Also the write data
    output logic                            cond_true
);

    localparam int DW = cpu_pkg::DATA_W;

    logic          c_flag;
    logic          z_flag;
    logic          n_flag;
    logic          v_flag;
    logic          sub;                                     // SBC or CMP
    logic [DW-1:0] add_b;                                   // Operand or its complement
    logic          add_ci;
    logic [DW:0]   sum;                                     // Carry out in top bit
    logic          add_v;
    logic [DW-1:0] result;
    logic          res_z;
    logic          upd;

    // Subtract as add of the complement, borrow is inverted carry
    assign sub    = (alu_op == cpu_pkg::SBC) || (alu_op == cpu_pkg::CMP);
    assign add_b  = sub ? ~operand : operand;
    assign add_ci = (alu_op == cpu_pkg::CMP) ? 1'b1 : c_flag;  // CMP ignores carry in
    assign sum    = {1'b0, acc} + {1'b0, add_b} + {{DW{1'b0}}, add_ci};

    // Signed overflow, like signs in and a different sign out
    assign add_v = (acc[DW-1] == add_b[DW-1]) && (sum[DW-1] != acc[DW-1]);

    always_comb begin
        case (alu_op)
            cpu_pkg::LDA: result = operand;
            cpu_pkg::ORA: result = acc | operand;
            cpu_pkg::AND: result = acc & operand;
            cpu_pkg::EOR: result = acc ^ operand;
            default:      result = sum[DW-1:0];             // ADC, SBC, CMP
        endcase
    end

    assign res_z = (result == '0);
    assign upd   = alu_en && (alu_op != cpu_pkg::NONE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc    <= '0;
            c_flag <= 1'b0;
            z_flag <= 1'b0;
            n_flag <= 1'b0;
            v_flag <= 1'b0;
        end else if (upd) begin
            case (alu_op)
                cpu_pkg::CLC: c_flag <= 1'b0;
                cpu_pkg::SEC: c_flag <= 1'b1;
                cpu_pkg::CMP: begin
                    c_flag <= sum[DW];                      // Set when A >= operand
                    z_flag <= res_z;
                    n_flag <= result[DW-1];                 // A kept
                end
                cpu_pkg::ADC, cpu_pkg::SBC: begin
                    acc    <= result;
                    c_flag <= sum[DW];
                    v_flag <= add_v;
                    z_flag <= res_z;
                    n_flag <= result[DW-1];
                end
                default: begin
                    acc    <= result;                       // LDA and logic ops
                    z_flag <= res_z;
                    n_flag <= result[DW-1];
                end
            endcase
        end
    end

    // Branch condition, flag picked by bits 2:1, sense by bit 0
    always_comb begin
        case (cond_code)
            3'b000:  cond_true = ~n_flag;                   // BPL
            3'b001:  cond_true = n_flag;                    // BMI
            3'b010:  cond_true = ~v_flag;                   // BVC
            3'b011:  cond_true = v_flag;                    // BVS
            3'b100:  cond_true = ~c_flag;                   // BCC
            3'b101:  cond_true = c_flag;                    // BCS
            3'b110:  cond_true = ~z_flag;                   // BNE
            default: cond_true = z_flag;                    // BEQ
        endcase
    end

endmodule

`default_nettype wire

// File: cpu_core.sv
// Top level of the reduced 6502-style core
// Decoder, sequencer and execute unit on the external memory bus
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
    parameter logic [cpu_pkg::ADDR_W-1:0] RESET_PC = 16'h0200  // First opcode address
) (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    output logic [cpu_pkg::ADDR_W-1:0]      addr,
    input  wire logic [cpu_pkg::DATA_W-1:0] data_in,    // Byte for last rdy-high address
    output logic [cpu_pkg::DATA_W-1:0]      data_out,
    output logic                            we_n,
    input  wire logic                       rdy
);

    cpu_pkg::state_t            next_state;
    cpu_pkg::alu_op_t           alu_op;
    logic                       store;
    logic [2:0]                 cond_code;
    logic [cpu_pkg::DATA_W-1:0] ir;
    logic                       decode_en;
    logic [cpu_pkg::DATA_W-1:0] operand;                // Held or live read byte
    logic                       alu_en;
    logic                       cond_true;

    cpu_decode u_decode (
        .clk        (clk),
        .reset_n    (reset_n),
        .ir         (ir),
        .decode_en  (decode_en),
        .next_state (next_state),
        .alu_op     (alu_op),
        .store      (store),
        .cond_code  (cond_code)
    );

    cpu_sequencer #(.RESET_PC(RESET_PC)) u_sequencer (
        .clk(clk), .reset_n(reset_n), .rdy(rdy), .data_in(data_in),
        .next_state(next_state), .store(store), .cond_true(cond_true),
        .ir(ir), .decode_en(decode_en), .operand(operand), .alu_en(alu_en),
        .addr(addr), .we_n(we_n)
    );

    cpu_execute u_execute (
        .clk(clk), .reset_n(reset_n), .alu_en(alu_en), .alu_op(alu_op),
        .operand(operand), .cond_code(cond_code),
        .acc(data_out),                                 // STA writes A
        .cond_true(cond_true)
    );

endmodule

`default_nettype wire

// File: cpu_core_assert.sv
// Concurrent bus checks for cpu_core, attached with bind
// Write enable in reset, bus hold during stalls, single write cycles
`timescale 1ns/100ps
`default_nettype none

module cpu_core_assert (
    input wire logic        clk,
    input wire logic        reset_n,
    input wire logic [15:0] addr,
    input wire logic [7:0]  data_out,
    input wire logic        we_n,
    input wire logic        rdy
);

    // No write may start while the core is held in reset
    we_n_in_reset: assert property (@(posedge clk) !reset_n |-> we_n)
        else $error("we_n low during reset");

    // A stalled cycle freezes the whole outgoing bus
    bus_hold: assert property (@(posedge clk) disable iff (!reset_n)
        !rdy |=> ($stable(addr) && $stable(we_n) && $stable(data_out)))
        else $error("bus changed after a stalled cycle");

    // STA writes for one accepted cycle only
    single_write: assert property (@(posedge clk) disable iff (!reset_n)
        (rdy && !we_n) |=> we_n)
        else $error("we_n low in two consecutive accepted cycles");

endmodule

bind cpu_core cpu_core_assert u_assert (
    .clk(clk), .reset_n(reset_n), .addr(addr), .data_out(data_out),
    .we_n(we_n), .rdy(rdy)
);

`default_nettype wire

// File: tb_cpu_core.sv
// Testbench for cpu_core
// Random program generator, 64 KB memory with rdy stalls
// Instruction-level model predicting the write list, watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;

    localparam logic [15:0] RESET_PC = 16'h0200;
    localparam int NBLK      = 40;                          // Program blocks
    localparam int WD_CYCLES = NBLK * 40 * 2;

    logic        clk = 1'b0;
    logic        reset_n = 1'b0;
    logic [15:0] addr;
    logic [7:0]  data_in = 8'h00;
    logic [7:0]  data_out;
    logic        we_n;
    logic        rdy = 1'b1;

    logic [7:0]  mem [0:65535];                             // DUT side memory
    logic [7:0]  mm  [0:65535];                             // Model copy
    logic [31:0] rng = 32'hc524bbc7;
    logic [15:0] s_addr;                                    // Bus sampled mid cycle
    logic [7:0]  s_dout;
    logic        s_we = 1'b1;
    logic        s_rdy = 1'b1;
    logic        s_rst = 1'b0;
    logic [15:0] exp_a [$];                                 // Predicted writes
    logic [7:0]  exp_d [$];
    logic [15:0] gpc;
    int          errors = 0;

    cpu_core #(.RESET_PC(RESET_PC)) u_dut (
        .clk(clk), .reset_n(reset_n), .addr(addr), .data_in(data_in),
        .data_out(data_out), .we_n(we_n), .rdy(rdy)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic emit(input logic [7:0] b);
        mem[gpc] = b;
        gpc = gpc + 16'd1;
    endtask

    // Random ALU or flag instruction, immediate or zero page
    task automatic emit_alu_op();
        logic [31:0] r;
        logic [2:0]  grp;
        r = next_rand();
        case (r % 9)
            0: grp = 3'd5;                                  // LDA
            1: grp = 3'd0;                                  // ORA
            2: grp = 3'd1;                                  // AND
            3: grp = 3'd2;                                  // EOR
            4: grp = 3'd3;                                  // ADC
            5: grp = 3'd7;                                  // SBC
            6: grp = 3'd6;                                  // CMP
            7: begin
                emit(cpu_pkg::CLC_IMP);
                return;
            end
            default: begin
                emit(cpu_pkg::SEC_IMP);
                return;
            end
        endcase
        emit({grp, r[8] ? 5'b01001 : 5'b00101});            // Imm or zp by bit 8
        emit(r[23:16]);
    endtask

    // Flags from ADC, SBC or CMP, random branch, then the LDA #1, STA pair
    task automatic emit_branch_test(input logic [31:0] r, input logic [7:0] offs);
        emit(cpu_pkg::LDA_IMM);
        emit(r[15:8]);
        case (r[5:4])
            2'd0:    emit(cpu_pkg::ADC_IMM);
            2'd1:    emit(cpu_pkg::SBC_IMM);
            default: emit(cpu_pkg::CMP_IMM);
        endcase
        emit(r[23:16]);
        emit({r[28:26], 5'b10000});                         // Any branch opcode
        emit(offs);
        emit(cpu_pkg::LDA_IMM);
        emit(8'h01);
        emit(cpu_pkg::STA_ZP);
        emit(8'h80 | r[31:24]);
    endtask

    task automatic gen_program();
        logic [31:0] r;
        logic [15:0] fin;
        logic [15:0] pb;
        gpc = RESET_PC;
        for (int b = 0; b < NBLK; b++) begin
            r = next_rand();
            if (r[0]) begin
                for (int i = 0; i <= int'(r[3:2]); i++)
                    emit_alu_op();
                emit(cpu_pkg::STA_ZP);
                emit(8'h80 | r[15:8]);
            end else if (r[1]) begin
                emit_branch_test(r, 8'h04);                 // Skip the LDA #1, STA pair
                emit(cpu_pkg::LDA_IMM);
                emit(8'h00);
                emit(cpu_pkg::STA_ZP);
                emit(8'h80 | r[31:24] ^ 8'h01);
            end else begin
                // Taken path at the end of the page before the branch
                pb = {gpc[15:8] + 8'd1, 8'h00};
                if (gpc + 16'd10 > pb)
                    pb = pb + 16'h0100;
                emit(cpu_pkg::JMP_ABS);
                emit(8'h00);
                emit(pb[15:8]);
                while (gpc != pb - 16'd7)
                    emit(cpu_pkg::STA_ZP);                  // Never executed
                emit(cpu_pkg::LDA_IMM);
                emit(8'h00);
                emit(cpu_pkg::STA_ZP);
                emit(8'h80 | r[31:24]);
                emit(cpu_pkg::JMP_ABS);
                emit(8'h0A);                                // Rejoin after the test
                emit(pb[15:8]);
                emit_branch_test(r, 8'hF3);                 // Back 13 bytes, new page
            end
        end
        fin = gpc + 16'd16;
        emit(cpu_pkg::JMP_ABS);
        emit(fin[7:0]);
        emit(fin[15:8]);
        while (gpc != fin)
            emit(cpu_pkg::STA_ZP);                          // Skipped bytes would write
        emit(cpu_pkg::STA_ZP);
        emit(8'h80);
        fin = gpc;
        emit(cpu_pkg::JMP_ABS);                             // Jump to itself
        emit(fin[7:0]);
        emit(fin[15:8]);
    endtask

    // Steps the program on a copy of memory and queues each write
    task automatic run_model();
        logic [15:0] pc;
        logic [15:0] tgt;
        logic [7:0]  op;
        logic [7:0]  b1;
        logic [7:0]  a;
        logic [7:0]  v;
        int          ures;
        int          sres;
        logic        fc;
        logic        fz;
        logic        fn;
        logic        fv;
        logic        flag;
        bit          halt;
        pc = RESET_PC;
        {a, fc, fz, fn, fv} = '0;
        halt = 0;
        ures = 0;
        for (int n = 0; n < NBLK * 20 && !halt; n++) begin
            op = mm[pc];
            b1 = mm[pc + 16'd1];
            if (op == cpu_pkg::STA_ZP) begin
                mm[{8'h00, b1}] = a;
                exp_a.push_back({8'h00, b1});
                exp_d.push_back(a);
                pc = pc + 16'd2;
            end else if (op == cpu_pkg::CLC_IMP || op == cpu_pkg::SEC_IMP) begin
                fc = op[5];
                pc = pc + 16'd1;
            end else if (op == cpu_pkg::JMP_ABS) begin
                tgt = {mm[pc + 16'd2], b1};
                halt = (tgt == pc);
                pc = tgt;
            end else if (op[4:0] == 5'b10000) begin
                pc = pc + 16'd2;
                case (op[7:6])
                    2'd0:    flag = fn;
                    2'd1:    flag = fv;
                    2'd2:    flag = fc;
                    default: flag = fz;
                endcase
                if (flag == op[5])
                    pc = pc + {{8{b1[7]}}, b1};
            end else begin
                v = (op[4:0] == 5'b01001) ? b1 : mm[{8'h00, b1}];
                pc = pc + 16'd2;
                case (op[7:5])
                    3'd0: a = a | v;
                    3'd1: a = a & v;
                    3'd2: a = a ^ v;
                    3'd5: a = v;
                    3'd3: begin                             // ADC, unsigned and signed sums
                        ures = int'(a) + int'(v) + int'(fc);
                        sres = int'($signed(a)) + int'($signed(v)) + int'(fc);
                        fc   = (ures > 255);
                        fv   = (sres > 127) || (sres < -128);
                        a    = ures[7:0];
                    end
                    3'd7: begin                             // SBC, borrow when C clear
                        ures = int'(a) - int'(v) - int'(!fc);
                        sres = int'($signed(a)) - int'($signed(v)) - int'(!fc);
                        fc   = (ures >= 0);
                        fv   = (sres > 127) || (sres < -128);
                        a    = ures[7:0];
                    end
                    default: begin                          // CMP, A unchanged
                        ures = int'(a) - int'(v);
                        fc   = (ures >= 0);
                    end
                endcase
                v  = (op[7:5] == 3'd6) ? ures[7:0] : a;
                fz = (v == 8'h00);
                fn = v[7];
            end
        end
    endtask

    task automatic check_write(input logic [15:0] a, input logic [7:0] d);
        assert (exp_a.size() != 0)
        else begin
            $display("Unexpected write of %02h at %04h after the last predicted one", d, a);
            errors++;
        end
        if (exp_a.size() != 0) begin
            assert (a == exp_a[0] && d == exp_d[0])
            else begin
                $display("MISMATCH write: expected %04h=%02h actual %04h=%02h",
                         exp_a[0], exp_d[0], a, d);
                errors++;
            end
            void'(exp_a.pop_front());
            void'(exp_d.pop_front());
        end
    endtask

    always @(negedge clk) begin
        s_addr = addr;
        s_dout = data_out;
        s_we   = we_n;
        s_rdy  = rdy;
        s_rst  = reset_n;
    end

    // Memory answers the address of the last accepted cycle
    always @(posedge clk) begin
        #1;
        if (s_rdy) begin
            data_in = mem[s_addr];
            if (!s_we && s_rst) begin
                mem[s_addr] = s_dout;
                check_write(s_addr, s_dout);
            end
        end
        rdy = !s_rst || (next_rand() % 4 != 0);             // About 25% stalls
    end

    initial begin
        for (int i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
        for (int i = 0; i < 128; i++)
            mem[i] = next_rand() >> 8;                      // Zero-page data
        gen_program();
        for (int i = 0; i < 65536; i++)
            mm[i] = mem[i];
        run_model();
        repeat (8) @(posedge clk);
        #1 reset_n = 1'b1;
        @(negedge clk);
        assert (addr == RESET_PC && we_n)
        else begin
            $display("MISMATCH reset fetch: expected %04h we_n=1 actual %04h we_n=%b",
                     RESET_PC, addr, we_n);
            errors++;
        end
        while (exp_a.size() != 0)
            @(posedge clk);
        repeat (40) @(posedge clk);                         // Catch stray writes
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial begin
        #((WD_CYCLES + 8) * 10);
        $display("Timeout with %0d writes still expected", exp_a.size());
        $display("Errors: %0d", errors + 1);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
cpu_pkg.sv
cpu_decode.sv
cpu_sequencer.sv
cpu_execute.sv
cpu_core.sv
cpu_core_assert.sv
tb_cpu_core.sv

// File: run.sh
#!/bin/sh
# Build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu_core -f sources.f -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
else
    exit 1
fi
